// File: project.f
+incdir+.
prog_pkg.sv
uart_rx.sv
iccm_controller.sv
instr_mem.sv
iccm_boot_top.sv
iccm_boot_assert.sv
tb_iccm_boot.sv

// File: run.sh
#!/bin/sh
# build and run the ICCM boot testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f project.f \
  --top-module tb_iccm_boot \
  -o sim_iccm_boot

# the simulator exits non-zero on failure, the output still decides
output=$(./obj_dir/sim_iccm_boot 2>&1) || true
echo "$output"

if echo "$output" | grep -qx '>>> PASS'; then
  exit 0
else
  exit 1
fi

// File: tb_iccm_boot.sv
`default_nettype none

`include "prog_config.svh"

module tb_iccm_boot;

  timeunit 1ns;
  timeprecision 1ps;

  import prog_pkg::*;

  localparam int N = 24;
  localparam int M = 10;
  localparam int DEPTH = 2 ** `PROG_ICCM_AW;
  localparam word_t END_WORD = `PROG_END_WORD;
  // both runs plus the dropped frame
  localparam int BYTES_SENT = 4 * ((N + 1) + (M + 2)) + 1;
  localparam int CYCLE_LIMIT = BYTES_SENT * 10 * `PROG_CLKS_PER_BIT + 2000;

  logic       clock = 1'b0;
  logic       arst_n_i;
  logic       uart_rx_i;
  logic       rd_req_i;
  iccm_addr_t rd_addr_i;
  word_t      rd_data_o;
  logic       rd_valid_o;
  logic       core_hold_o;

  int         seed = 32'h5bad8390;
  int         cycle_cnt = 0;

  // reference memory, with a flag for entries whose content is known
  word_t      ref_mem [DEPTH];
  bit         known [DEPTH];
  iccm_addr_t wr_addr;
  bit         done_seen;

  logic       req_prev;
  iccm_addr_t addr_prev;

  iccm_boot_top DUT (
    .clock       (clock),
    .arst_n_i    (arst_n_i),
    .uart_rx_i   (uart_rx_i),
    .rd_req_i    (rd_req_i),
    .rd_addr_i   (rd_addr_i),
    .rd_data_o   (rd_data_o),
    .rd_valid_o  (rd_valid_o),
    .core_hold_o (core_hold_o)
  );

  initial begin
    forever #5 clock = ~clock;
  end

  function automatic word_t expected_word(iccm_addr_t addr);
    return ref_mem[addr];
  endfunction

  function automatic word_t draw_word();
    word_t w;
    do begin
      w = $random(seed);
    end while (w == END_WORD);
    return w;
  endfunction

  task automatic fail_run();
    $display(">>> FAIL");
    $fatal(1);
  endtask

  task automatic check_word(word_t got, word_t exp, iccm_addr_t addr);
    if (got !== exp) begin
      $display("Mismatch at %0t: addr 0x%h read 0x%h, expected 0x%h", $time, addr, got, exp);
      fail_run();
    end
  endtask

  task automatic check_hold(logic got, logic exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: core_hold_o is %b, expected %b", $time, got, exp);
      fail_run();
    end
  endtask

  task automatic check_valid(logic got, logic exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: rd_valid_o is %b, expected %b", $time, got, exp);
      fail_run();
    end
  endtask

  task automatic apply_reset();
    @(posedge clock);
    arst_n_i <= 1'b0;
    repeat (2) @(posedge clock);
    arst_n_i <= 1'b1;
  endtask

  // one serial bit, driven right after a rising edge
  task automatic drive_bit(logic v);
    @(posedge clock);
    uart_rx_i <= v;
    repeat (`PROG_CLKS_PER_BIT - 1) @(posedge clock);
  endtask

  task automatic send_byte(byte_t b, bit bad_stop);
    drive_bit(1'b0);
    for (int i = 0; i < 8; i++) begin
      drive_bit(b[i]);
    end
    drive_bit(!bad_stop);
    // line back to idle so the receiver can leave its error wait
    if (bad_stop) begin
      drive_bit(1'b1);
    end
  endtask

  // bad_pos selects the byte that a dropped frame precedes, -1 for none
  task automatic send_word(word_t w, int bad_pos);
    byte_t junk;
    for (int i = 0; i < 4; i++) begin
      if (i == bad_pos) begin
        junk = byte_t'($random(seed));
        send_byte(junk, 1'b1);
      end
      send_byte(w[8*i +: 8], 1'b0);
    end
  endtask

  task automatic program_word(word_t w, int bad_pos);
    send_word(w, bad_pos);
    if (!done_seen) begin
      if (w == END_WORD) begin
        done_seen = 1'b1;
      end else begin
        ref_mem[wr_addr] = w;
        known[wr_addr]   = 1'b1;
        wr_addr          = wr_addr + 1'b1;
      end
    end
  endtask

  task automatic sample_hold(logic exp);
    @(negedge clock);
    check_hold(core_hold_o, exp);
  endtask

  task automatic read_addr(iccm_addr_t addr);
    @(posedge clock);
    rd_req_i  <= 1'b1;
    rd_addr_i <= addr;
    @(posedge clock);
    rd_req_i  <= 1'b0;
    @(posedge clock);
  endtask

  // compare process, read response due one cycle after each request
  always @(negedge clock) begin
    if (!arst_n_i) begin
      check_valid(rd_valid_o, 1'b0);
      req_prev = 1'b0;
    end else begin
      check_valid(rd_valid_o, req_prev);
      if (req_prev) begin
        if (known[addr_prev]) begin
          check_word(rd_data_o, expected_word(addr_prev), addr_prev);
        end else begin
          // never written, so whatever it holds must stay
          ref_mem[addr_prev] = rd_data_o;
          known[addr_prev]   = 1'b1;
        end
      end
      req_prev  = rd_req_i;
      addr_prev = rd_addr_i;
    end
  end

  always @(posedge clock) begin
    cycle_cnt++;
    if (cycle_cnt > CYCLE_LIMIT) begin
      $display("run timed out after %0d cycles", cycle_cnt);
      $display(">>> FAIL");
      $fatal(1);
    end
  end

  initial begin
    word_t w;
    arst_n_i  = 1'b0;
    uart_rx_i = 1'b1;
    rd_req_i  = 1'b0;
    rd_addr_i = '0;
    req_prev  = 1'b0;
    addr_prev = '0;
    wr_addr   = '0;
    done_seen = 1'b0;
    for (int a = 0; a < DEPTH; a++) begin
      known[a] = 1'b0;
    end

    apply_reset();
    sample_hold(1'b1);
    read_addr(iccm_addr_t'(N));

    // first run
    for (int i = 0; i < N; i++) begin
      w = draw_word();
      program_word(w, -1);
      sample_hold(1'b1);
    end
    program_word(END_WORD, -1);
    drive_bit(1'b1);
    sample_hold(1'b0);
    for (int a = 0; a <= N; a++) begin
      read_addr(iccm_addr_t'(a));
    end

    // second run, one dropped frame inside word 4
    apply_reset();
    sample_hold(1'b1);
    wr_addr   = '0;
    done_seen = 1'b0;
    for (int i = 0; i < M; i++) begin
      w = draw_word();
      program_word(w, (i == 4) ? 2 : -1);
      sample_hold(1'b1);
    end
    program_word(END_WORD, -1);
    drive_bit(1'b1);
    sample_hold(1'b0);
    w = draw_word();
    program_word(w, -1);
    drive_bit(1'b1);
    sample_hold(1'b0);
    for (int a = 0; a <= N; a++) begin
      read_addr(iccm_addr_t'(a));
    end

    repeat (2) @(posedge clock);
    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: iccm_boot_assert.sv
`default_nettype none

`include "prog_config.svh"

module iccm_boot_assert (
  input  logic clock,
  input  logic arst_n_i,
  input  logic rd_req_i,
  input  logic rd_valid_i,
  input  logic core_hold_i,
  input  logic we_i,
  input  logic rx_dv_i
);

  timeunit 1ns;
  timeprecision 1ps;

  import prog_pkg::*;

  // byte strobes come at most once per frame
  localparam baud_cnt_t MIN_GAP = baud_cnt_t'(9 * `PROG_CLKS_PER_BIT);

  baud_cnt_t gap_q;

  always_ff @(posedge clock or negedge arst_n_i) begin
    if (!arst_n_i) begin
      gap_q <= '1;
    end else if (rx_dv_i) begin
      gap_q <= '0;
    end else if (gap_q != '1) begin
      gap_q <= gap_q + 16'd1;
    end
  end

  a_rd_valid: assert property (@(posedge clock) disable iff (!arst_n_i)
    rd_req_i |=> rd_valid_i)
    else $error("read response missing one cycle after request");

  a_rd_idle: assert property (@(posedge clock) disable iff (!arst_n_i)
    !rd_req_i |=> !rd_valid_i)
    else $error("read response without request");

  // once released, hold stays low and no write follows until reset
  a_we_hold: assert property (@(posedge clock) disable iff (!arst_n_i)
    !core_hold_i |=> !core_hold_i && !we_i)
    else $error("ICCM write or hold change after core hold release");

  a_rx_pulse: assert property (@(posedge clock) disable iff (!arst_n_i)
    rx_dv_i |=> !rx_dv_i)
    else $error("rx_dv high for two cycles");

  a_rx_gap: assert property (@(posedge clock) disable iff (!arst_n_i)
    rx_dv_i |-> gap_q >= MIN_GAP)
    else $error("rx_dv strobes closer than one frame");

endmodule

bind iccm_boot_top iccm_boot_assert u_boot_assert (
  .clock       (clock),
  .arst_n_i    (arst_n_i),
  .rd_req_i    (rd_req_i),
  .rd_valid_i  (rd_valid_o),
  .core_hold_i (core_hold_o),
  .we_i        (we),
  .rx_dv_i     (rx_dv)
);

`default_nettype wire

// File: iccm_boot_top.sv
`default_nettype none

module iccm_boot_top (
  input  logic                 clock,
  input  logic                 arst_n_i,
  input  logic                 uart_rx_i,
  input  logic                 rd_req_i,
  input  prog_pkg::iccm_addr_t rd_addr_i,
  output prog_pkg::word_t      rd_data_o,
  output logic                 rd_valid_o,
  output logic                 core_hold_o
);

  import prog_pkg::*;

  // receiver to controller
  logic       rx_dv;
  byte_t      rx_byte;

  // controller write port into the ICCM
  logic       we;
  iccm_addr_t waddr;
  word_t      wdata;

  uart_rx u_uart_rx (
    .clock     (clock),
    .arst_n_i  (arst_n_i),
    .rx_i      (uart_rx_i),
    .rx_dv_o   (rx_dv),
    .rx_byte_o (rx_byte)
  );

  iccm_controller u_iccm_ctrl (
    .clock       (clock),
    .arst_n_i    (arst_n_i),
    .rx_dv_i     (rx_dv),
    .rx_byte_i   (rx_byte),
    .we_o        (we),
    .waddr_o     (waddr),
    .wdata_o     (wdata),
    .core_hold_o (core_hold_o)
  );

  // read port stands in for the fetch path
  instr_mem u_iccm (
    .clock      (clock),
    .arst_n_i   (arst_n_i),
    .we_i       (we),
    .waddr_i    (waddr),
    .wdata_i    (wdata),
    .rd_req_i   (rd_req_i),
    .rd_addr_i  (rd_addr_i),
    .rd_data_o  (rd_data_o),
    .rd_valid_o (rd_valid_o)
  );

endmodule

`default_nettype wire

// File: instr_mem.sv
`default_nettype none

`include "prog_config.svh"

module instr_mem #(
  parameter int AW = `PROG_ICCM_AW
) (
  input  logic                 clock,
  input  logic                 arst_n_i,
  input  logic                 we_i,
  input  prog_pkg::iccm_addr_t waddr_i,
  input  prog_pkg::word_t      wdata_i,
  input  logic                 rd_req_i,
  input  prog_pkg::iccm_addr_t rd_addr_i,
  output prog_pkg::word_t      rd_data_o,
  output logic                 rd_valid_o
);

  import prog_pkg::*;

  localparam int DEPTH = 2 ** AW;

  word_t mem [DEPTH];
  word_t rd_data_q;
  logic  rd_valid_q;

  always_ff @(posedge clock) begin
    if (we_i) begin
      mem[waddr_i[AW-1:0]] <= wdata_i;
    end
  end

  // same address read and write returns old data
  always_ff @(posedge clock) begin
    if (rd_req_i) begin
      rd_data_q <= mem[rd_addr_i[AW-1:0]];
    end
  end

  always_ff @(posedge clock or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rd_valid_q <= 1'b0;
    end else begin
      rd_valid_q <= rd_req_i;
    end
  end

  assign rd_data_o  = rd_data_q;
  assign rd_valid_o = rd_valid_q;

endmodule

`default_nettype wire

// File: iccm_controller.sv
`default_nettype none

`include "prog_config.svh"

module iccm_controller (
  input  logic                 clock,
  input  logic                 arst_n_i,
  input  logic                 rx_dv_i,
  input  prog_pkg::byte_t      rx_byte_i,
  output logic                 we_o,
  output prog_pkg::iccm_addr_t waddr_o,
  output prog_pkg::word_t      wdata_o,
  output logic                 core_hold_o
);

  import prog_pkg::*;

  localparam word_t END_WORD = `PROG_END_WORD;

  prog_state_e state_q;
  logic [1:0]  byte_cnt_q;
  iccm_addr_t  addr_q;
  word_t       word_q;
  logic        byte_last;
  logic        end_word;

  assign byte_last = (byte_cnt_q == 2'd3);
  assign end_word  = (word_q == END_WORD);

  always_ff @(posedge clock or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q    <= PROG_COLLECT;
      byte_cnt_q <= '0;
      addr_q     <= '0;
    end else begin
      case (state_q)
        PROG_COLLECT: begin
          if (rx_dv_i) begin
            // counter wraps to zero after the fourth byte
            byte_cnt_q <= byte_cnt_q + 2'd1;
            if (byte_last) begin
              state_q <= PROG_WRITE;
            end
          end
        end
        PROG_WRITE: begin
          if (end_word) begin
            state_q <= PROG_DONE;
          end else begin
            addr_q  <= addr_q + 1'b1;
            state_q <= PROG_COLLECT;
          end
        end
        PROG_DONE: begin
          // stays here until reset
          state_q <= PROG_DONE;
        end
        default: begin
          state_q <= PROG_COLLECT;
        end
      endcase
    end
  end

  // new byte enters at the top, first byte ends up in bits 7:0
  always_ff @(posedge clock) begin
    if (state_q == PROG_COLLECT && rx_dv_i) begin
      word_q <= {rx_byte_i, word_q[31:8]};
    end
  end

  // end word is never written
  assign we_o        = (state_q == PROG_WRITE) && !end_word;
  assign waddr_o     = addr_q;
  assign wdata_o     = word_q;
  assign core_hold_o = (state_q != PROG_DONE);

endmodule

`default_nettype wire

// File: uart_rx.sv
`default_nettype none

`include "prog_config.svh"

module uart_rx #(
  parameter int CLKS_PER_BIT = `PROG_CLKS_PER_BIT
) (
  input  logic            clock,
  input  logic            arst_n_i,
  input  logic            rx_i,
  output logic            rx_dv_o,
  output prog_pkg::byte_t rx_byte_o
);

  import prog_pkg::*;

  typedef enum logic [2:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP,
    RX_WAIT_IDLE
  } rx_state_e;

  // last count of a full bit and of half a bit
  localparam baud_cnt_t BIT_LAST  = baud_cnt_t'(CLKS_PER_BIT - 1);
  localparam baud_cnt_t HALF_LAST = baud_cnt_t'(CLKS_PER_BIT / 2 - 1);

  logic      rx_meta;
  logic      rx_sync;
  rx_state_e state_q;
  baud_cnt_t cnt_q;
  logic [2:0] bit_idx_q;
  logic      rx_dv_q;
  byte_t     shift_q;
  logic      bit_tick;
  logic      half_tick;

  // two flop synchronizer, line idles high
  always_ff @(posedge clock or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end else begin
      rx_meta <= rx_i;
      rx_sync <= rx_meta;
    end
  end

  assign bit_tick  = (cnt_q == BIT_LAST);
  assign half_tick = (cnt_q == HALF_LAST);

  always_ff @(posedge clock or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q   <= RX_IDLE;
      cnt_q     <= '0;
      bit_idx_q <= '0;
      rx_dv_q   <= 1'b0;
    end else begin
      rx_dv_q <= 1'b0;
      case (state_q)
        RX_IDLE: begin
          cnt_q     <= '0;
          bit_idx_q <= '0;
          // falling edge starts a frame
          if (!rx_sync) begin
            state_q <= RX_START;
          end
        end
        RX_START: begin
          if (half_tick) begin
            cnt_q <= '0;
            // glitch if the line went back high
            if (!rx_sync) begin
              state_q <= RX_DATA;
            end else begin
              state_q <= RX_IDLE;
            end
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        RX_DATA: begin
          if (bit_tick) begin
            cnt_q     <= '0;
            bit_idx_q <= bit_idx_q + 1'b1;
            if (bit_idx_q == 3'd7) begin
              state_q <= RX_STOP;
            end
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        RX_STOP: begin
          if (bit_tick) begin
            cnt_q <= '0;
            if (rx_sync) begin
              rx_dv_q <= 1'b1;
              state_q <= RX_IDLE;
            end else begin
              // framing error, byte is dropped
              state_q <= RX_WAIT_IDLE;
            end
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        RX_WAIT_IDLE: begin
          if (rx_sync) begin
            state_q <= RX_IDLE;
          end
        end
        default: begin
          state_q <= RX_IDLE;
        end
      endcase
    end
  end

  // data bits arrive lsb first
  always_ff @(posedge clock) begin
    if (state_q == RX_DATA && bit_tick) begin
      shift_q <= {rx_sync, shift_q[7:1]};
    end
  end

  assign rx_dv_o   = rx_dv_q;
  assign rx_byte_o = shift_q;

endmodule

`default_nettype wire

// File: prog_pkg.sv
`default_nettype none

`include "prog_config.svh"

package prog_pkg;

  // one serial byte
  typedef logic [7:0] byte_t;

  // one instruction word
  typedef logic [31:0] word_t;

  // word address into the ICCM
  typedef logic [`PROG_ICCM_AW-1:0] iccm_addr_t;

  // bit period counter of the receiver
  typedef logic [15:0] baud_cnt_t;

  // programming controller states
  typedef enum logic [1:0] {
    PROG_COLLECT,
    PROG_WRITE,
    PROG_DONE
  } prog_state_e;

endpackage

`default_nettype wire

// File: prog_config.svh
`ifndef PROG_CONFIG_SVH
`define PROG_CONFIG_SVH

// clock cycles per serial bit, must be 4 or more
`define PROG_CLKS_PER_BIT 16

// instruction memory address width in words
`define PROG_ICCM_AW 12

// word that ends a programming run; it is never written
`define PROG_END_WORD 32'h0000_0FFF

`endif
